/* testbench/aes_cbc_stim.txt */
# rec <name> <blocks>, then key <round key> for index 0 to 14, iv <iv>,
# then blk <ciphertext> <expected plaintext> per block, all values hex
rec sp800_38a_cbc_aes256 4
key 603deb1015ca71be2b73aef0857d7781
key 1f352c073b6108d72d9810a30914dff4
key 9ba354118e6925afa51a8b5f2067fcde
key a8b09c1a93d194cdbe49846eb75d5b9a
key d59aecb85bf3c917fee94248de8ebe96
key b5a9328a2678a647983122292f6c79b3
key 812c81addadf48ba24360af2fab8b464
key 98c5bfc9bebd198e268c3ba709e04214
key 68007bacb2df331696e939e46c518d80
key c814e20476a9fb8a5025c02d59c58239
key de1369676ccc5a71fa2563959674ee15
key 5886ca5d2e2f31d77e0af1fa27cf73c3
key 749c47ab18501ddae2757e4f7401905a
key cafaaae3e4d59b349adf6acebd10190d
key fe4890d1e6188d0b046df344706c631e
iv  000102030405060708090a0b0c0d0e0f
blk f58c4c04d6e5f1ba779eabfb5f7bfbd6 6bc1bee22e409f96e93d7e117393172a
blk 9cfc4e967edb808d679f777bc6702c7d ae2d8a571e03ac9c9eb76fac45af8e51
blk 39f23369a9d9bacfa530e26304231461 30c81c46a35ce411e5fbc1191a0a52ef
blk b2eb05e2c39be9fcda6c19078c6a9d1b f69f2445df4f9b17ad2b417be66c3710
# second key set, FIPS-197 appendix C.3 key, zero IV
rec fips197_c3_aes256 3
key 000102030405060708090a0b0c0d0e0f
key 101112131415161718191a1b1c1d1e1f
key a573c29fa176c498a97fce93a572c09c
key 1651a8cd0244beda1a5da4c10640bade
key ae87dff00ff11b68a68ed5fb03fc1567
key 6de1f1486fa54f9275f8eb5373b8518d
key c656827fc9a799176f294cec6cd5598b
key 3de23a75524775e727bf9eb45407cf39
key 0bdc905fc27b0948ad5245a4c1871c2f
key 45f5a66017b2d387300d4d33640a820a
key 7ccff71cbeb4fe5413e6bbf0d261a7df
key f01afafee7a82979d7a5644ab3afe640
key 2541fe719bf500258813bbd55a721c0a
key 4e5a6699a9f24fe07e572baacdf8cdea
key 24fc79ccbf0979e9371ac23c6d68de36
iv  00000000000000000000000000000000
blk 8ea2b7ca516745bfeafc49904b496089 00112233445566778899aabbccddeeff
blk 8ea2b7ca516745bfeafc49904b496089 8eb395f9153223c86265e32b87948e76
blk 8ea2b7ca516745bfeafc49904b496089 8eb395f9153223c86265e32b87948e76

/* vlog.f */
+incdir+hdl
hdl/aes_data_pkg.sv
hdl/aes_ctrl_pkg.sv
hdl/aes_load_port.sv
hdl/aes_inv_round.sv
hdl/aes_dec_core.sv
hdl/aes_plain_port.sv
hdl/aes256_cbc_dec.sv
testbench/tb_aes256_cbc_dec.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= tb_aes256_cbc_dec
RTL_TOP   ?= aes256_cbc_dec
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS ?= --lint-only -Wall

SIM_BIN   = $(OBJ_DIR)/V$(TB_TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))
RTL_ARGS  = $(shell grep -v '^testbench/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) hdl/aes_params.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "no result found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_ARGS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_aes256_cbc_dec.sv */
`include "aes_params.svh"

module tb_aes256_cbc_dec;
    timeunit 1ns;
    timeprecision 1ps;

    import aes_data_pkg::*;

    localparam string       STIM_FILE   = "testbench/aes_cbc_stim.txt";
    localparam int          MAX_RECS    = 4;
    localparam int          MAX_BLOCKS  = 8;
    localparam int          NUM_KEYS    = `AES_NUM_ROUND_KEYS;
    localparam int          CLK_PERIOD  = 20;
    localparam logic [31:0] LFSR_SEED   = 32'h5e91_efb8;
    // worst case per word is the block run plus a full gap on each side and handshake overhead
    localparam int          WORD_CYCLES = 16 + 2 * 31 + 8;

    logic       clk;
    logic       resetn;
    logic       in_req;
    aes_block_t in_data;
    logic       in_ack;
    logic       out_req;
    aes_block_t out_data;
    logic       out_ack;

    string       rec_name  [MAX_RECS];
    int          rec_count [MAX_RECS];
    aes_block_t  rec_keys  [MAX_RECS][NUM_KEYS];
    aes_block_t  rec_iv    [MAX_RECS];
    aes_block_t  rec_ct    [MAX_RECS][MAX_BLOCKS];
    aes_block_t  rec_pt    [MAX_RECS][MAX_BLOCKS];
    int          num_recs;
    int          out_count;
    int          num_checks;
    int          num_errors;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] host_lfsr;
    logic [31:0] resp_lfsr;

    aes256_cbc_dec aes256_cbc_dec_inst (
        .clk        (clk),
        .resetn     (resetn),
        .in_req_i   (in_req),
        .in_data_i  (in_data),
        .in_ack_o   (in_ack),
        .out_req_o  (out_req),
        .out_data_o (out_data),
        .out_ack_i  (out_ack)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------
    // random gaps

    // galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step(inout logic [31:0] state);
        logic out_bit;
        out_bit = state[0];
        state   = state >> 1;
        if (out_bit) begin
            state = state ^ 32'h8020_0003;
        end
        return out_bit;
    endfunction

    // 5 bits give 0 to 31 cycles
    function automatic int draw_gap(inout logic [31:0] state);
        int gap;
        gap = 0;
        for (int i = 0; i < 5; i++) begin
            gap = (gap << 1) | int'(lfsr_step(state));
        end
        return gap;
    endfunction

    // ------------------------------
    // checks
    task automatic check_block(input string name, input aes_block_t expected,
                               input aes_block_t actual);
        num_checks++;
        if (actual !== expected) begin
            num_errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        num_checks++;
        if (actual != expected) begin
            num_errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        num_checks++;
        if (actual !== expected) begin
            num_errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // ------------------------------
    // stimulus file
    task automatic load_stim();
        int         fd;
        int         n;
        int         count;
        int         key_fill;
        int         blk_fill;
        string      line;
        string      tag;
        string      name;
        aes_block_t a;
        aes_block_t b;
        num_recs = 0;
        key_fill = 0;
        blk_fill = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open stimulus file %s", STIM_FILE);
            num_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s", tag);
            if (n == 1 && tag == "rec" && num_recs < MAX_RECS) begin
                n = $sscanf(line, "%s %s %d", tag, name, count);
                if (count > MAX_BLOCKS) begin
                    $display("ERROR: record %s has more blocks than the bench holds", name);
                    num_errors++;
                    count = MAX_BLOCKS;
                end
                rec_name[num_recs]  = name;
                rec_count[num_recs] = count;
                num_recs++;
                key_fill = 0;
                blk_fill = 0;
            end else if (n == 1 && tag == "key" && num_recs > 0 && key_fill < NUM_KEYS) begin
                n = $sscanf(line, "%s %h", tag, a);
                rec_keys[num_recs - 1][key_fill] = a;
                key_fill++;
            end else if (n == 1 && tag == "iv" && num_recs > 0) begin
                n = $sscanf(line, "%s %h", tag, a);
                rec_iv[num_recs - 1] = a;
            end else if (n == 1 && tag == "blk" && num_recs > 0 && blk_fill < MAX_BLOCKS) begin
                n = $sscanf(line, "%s %h %h", tag, a, b);
                rec_ct[num_recs - 1][blk_fill] = a;
                rec_pt[num_recs - 1][blk_fill] = b;
                blk_fill++;
            end
        end
        $fclose(fd);
        if (num_recs == 0) begin
            $display("ERROR: no records found in %s", STIM_FILE);
            num_errors++;
        end
    endtask

    function automatic longint run_limit_ns();
        longint total;
        total = 1000;
        for (int r = 0; r < num_recs; r++) begin
            // each record runs twice and keys and IV count as words too
            total += 2 * ((NUM_KEYS + 1 + rec_count[r]) * WORD_CYCLES * 4 + 64) * CLK_PERIOD;
        end
        return total;
    endfunction

    // ------------------------------
    // host side of both handshakes
    task automatic send_word(input aes_block_t word, input logic use_gaps);
        int gap;
        gap = 0;
        if (use_gaps) begin
            gap = draw_gap(host_lfsr);
        end
        repeat (gap) @(posedge clk);
        in_req  <= 1'b1;
        in_data <= word;
        @(posedge clk);
        while (!in_ack) @(posedge clk);
        in_req <= 1'b0;
        @(posedge clk);
        while (in_ack) @(posedge clk);
    endtask

    task automatic send_record(input int r, input logic use_gaps);
        for (int k = 0; k < NUM_KEYS; k++) begin
            send_word(rec_keys[r][k], use_gaps);
        end
        send_word(rec_iv[r], use_gaps);
        for (int i = 0; i < rec_count[r]; i++) begin
            send_word(rec_ct[r][i], use_gaps);
        end
    endtask

    task automatic collect_outputs(input int r, input logic use_gaps, input string run_name);
        int         gap;
        logic       extra_seen;
        aes_block_t first_seen;
        aes_block_t held;
        out_count  = 0;
        extra_seen = 1'b0;
        while (out_count < rec_count[r]) begin
            @(posedge clk);
            if (out_req) begin
                first_seen = out_data;
                held       = out_data;
                gap        = 0;
                if (use_gaps) begin
                    gap = draw_gap(resp_lfsr);
                end
                // data has to hold while the ack is delayed
                repeat (gap) begin
                    @(posedge clk);
                    if (out_data !== first_seen) begin
                        held = out_data;
                    end
                end
                check_block($sformatf("%s block %0d", run_name, out_count),
                            rec_pt[r][out_count], first_seen);
                out_ack <= 1'b1;
                @(posedge clk);
                while (out_req) begin
                    if (out_data !== first_seen) begin
                        held = out_data;
                    end
                    @(posedge clk);
                end
                check_block($sformatf("%s block %0d stable", run_name, out_count),
                            first_seen, held);
                out_ack <= 1'b0;
                out_count++;
            end
        end
        // a duplicate block would raise another request here
        repeat (40) begin
            @(posedge clk);
            if (out_req && !extra_seen) begin
                extra_seen = 1'b1;
                out_count++;
            end
        end
    endtask

    task automatic run_record(input int r, input logic use_gaps);
        string run_name;
        int    errors_before;
        run_name      = use_gaps ? {rec_name[r], "/random_gaps"} : {rec_name[r], "/streaming"};
        errors_before = num_errors;
        // a running DUT is reset with both handshakes still raised
        if (resetn === 1'b1) begin
            in_req  <= 1'b1;
            in_data <= rec_ct[r][0];
            @(posedge clk);
            while (!(in_ack && out_req)) @(posedge clk);
        end
        resetn  <= 1'b0;
        out_ack <= 1'b0;
        repeat (8) @(posedge clk);
        resetn <= 1'b1;
        in_req <= 1'b0;
        @(posedge clk);
        check_level({run_name, " in_ack after reset"}, 1'b0, in_ack);
        check_level({run_name, " out_req after reset"}, 1'b0, out_req);
        check_block({run_name, " out_data after reset"}, '0, out_data);
        fork
            send_record(r, use_gaps);
            collect_outputs(r, use_gaps, run_name);
        join
        check_count({run_name, " output count"}, rec_count[r], out_count);
        if (num_errors == errors_before) begin
            tests_passed++;
            $display("test %s: passed", run_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", run_name, num_errors - errors_before);
        end
    endtask

    // ------------------------------
    // main sequence
    initial begin
        longint limit_ns;
        resetn       = 1'b0;
        in_req       = 1'b0;
        in_data      = '0;
        out_ack      = 1'b0;
        host_lfsr    = LFSR_SEED;
        resp_lfsr    = LFSR_SEED;
        num_checks   = 0;
        num_errors   = 0;
        tests_passed = 0;
        tests_failed = 0;
        load_stim();
        limit_ns = run_limit_ns();
        fork
            begin
                #(limit_ns);
                $display("ERROR: no progress after %0d ns, the DUT stopped answering", limit_ns);
                $display("STATUS: FAIL");
                $finish;
            end
        join_none
        if (num_errors == 0) begin
            for (int r = 0; r < num_recs; r++) begin
                run_record(r, 1'b1);
                run_record(r, 1'b0);
            end
        end
        $display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, num_checks, num_errors);
        if (num_errors == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* hdl/aes256_cbc_dec.sv */
module aes256_cbc_dec (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     in_req_i,
    input  aes_data_pkg::aes_block_t in_data_i,
    output logic                     in_ack_o,
    output logic                     out_req_o,
    output aes_data_pkg::aes_block_t out_data_o,
    input  logic                     out_ack_i
);
    import aes_data_pkg::*;

    logic       word_valid;
    aes_block_t word_data;
    logic       word_take;
    logic       plain_valid;
    aes_block_t plain_data;
    logic       out_busy;

    // input side, holds one key, IV or ciphertext word
    aes_load_port aes_load_port_inst (
        .clk          (clk),
        .resetn       (resetn),
        .in_req_i     (in_req_i),
        .in_data_i    (in_data_i),
        .in_ack_o     (in_ack_o),
        .word_valid_o (word_valid),
        .word_o       (word_data),
        .word_take_i  (word_take)
    );

    aes_dec_core aes_dec_core_inst (
        .clk           (clk),
        .resetn        (resetn),
        .word_valid_i  (word_valid),
        .word_i        (word_data),
        .word_take_o   (word_take),
        .plain_valid_o (plain_valid),
        .plain_o       (plain_data),
        .out_busy_i    (out_busy)
    );

    // output side
    aes_plain_port aes_plain_port_inst (
        .clk           (clk),
        .resetn        (resetn),
        .plain_valid_i (plain_valid),
        .plain_i       (plain_data),
        .busy_o        (out_busy),
        .out_req_o     (out_req_o),
        .out_data_o    (out_data_o),
        .out_ack_i     (out_ack_i)
    );

endmodule

/* hdl/aes_plain_port.sv */
module aes_plain_port (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     plain_valid_i,
    input  aes_data_pkg::aes_block_t plain_i,
    output logic                     busy_o,
    output logic                     out_req_o,
    output aes_data_pkg::aes_block_t out_data_o,
    input  logic                     out_ack_i
);
    import aes_ctrl_pkg::*;

    tx_state_t tx_state;

    // ------------------------------
    // four-phase sender
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            tx_state   <= TX_IDLE;
            out_data_o <= '0;
        end else begin
            case (tx_state)
                TX_IDLE: begin
                    if (plain_valid_i) begin
                        out_data_o <= plain_i;
                        tx_state   <= TX_REQ;
                    end
                end
                TX_REQ: begin
                    if (out_ack_i) begin
                        tx_state <= TX_WAIT_DROP;
                    end
                end
                TX_WAIT_DROP: begin
                    // free again only once the host has released ack
                    if (!out_ack_i) begin
                        tx_state <= TX_IDLE;
                    end
                end
                default: begin
                    tx_state <= TX_IDLE;
                end
            endcase
        end
    end

    assign out_req_o = (tx_state == TX_REQ);
    assign busy_o    = (tx_state != TX_IDLE);

    a_data_stable: assert property (
        @(posedge clk) disable iff (!resetn) out_req_o |=> !out_req_o || $stable(out_data_o)
    );

endmodule

/* hdl/aes_dec_core.sv */
`include "aes_params.svh"

module aes_dec_core (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     word_valid_i,
    input  aes_data_pkg::aes_block_t word_i,
    output logic                     word_take_o,
    output logic                     plain_valid_o,
    output aes_data_pkg::aes_block_t plain_o,
    input  logic                     out_busy_i
);
    import aes_data_pkg::*;
    import aes_ctrl_pkg::*;

    dec_state_t dec_state;
    round_idx_t key_idx;
    logic       load_slot;
    logic       last_round;

    aes_block_t round_keys [`AES_NUM_ROUND_KEYS];
    aes_block_t state_q;
    aes_block_t cipher_q;
    aes_block_t chain_q;
    aes_block_t round_out;

    // words are only consumed while loading or idle between blocks
    assign load_slot   = (dec_state == LOAD_KEYS) || (dec_state == LOAD_IV)
                      || (dec_state == WAIT_BLOCK);
    assign word_take_o = word_valid_i && load_slot;
    assign last_round  = (key_idx == '0);

    assign plain_valid_o = (dec_state == DELIVER) && !out_busy_i;
    assign plain_o       = state_q ^ chain_q;

    aes_inv_round aes_inv_round_inst (
        .state_i     (state_q),
        .round_key_i (round_keys[key_idx]),
        .last_i      (last_round),
        .state_o     (round_out)
    );

    // ------------------------------
    // control FSM
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            dec_state <= LOAD_KEYS;
            key_idx   <= '0;
        end else begin
            case (dec_state)
                LOAD_KEYS: begin
                    if (word_take_o) begin
                        if (key_idx == round_idx_t'(`AES_NUM_ROUNDS)) begin
                            dec_state <= LOAD_IV;
                        end else begin
                            key_idx <= key_idx + 1'b1;
                        end
                    end
                end
                LOAD_IV: begin
                    if (word_take_o) begin
                        dec_state <= WAIT_BLOCK;
                    end
                end
                WAIT_BLOCK: begin
                    if (word_take_o) begin
                        dec_state <= KEY_ADD;
                    end
                end
                KEY_ADD: begin
                    key_idx   <= round_idx_t'(`AES_NUM_ROUNDS - 1);
                    dec_state <= ROUNDS;
                end
                ROUNDS: begin
                    // round 0 is the last one, key_idx then stays at zero
                    if (last_round) begin
                        dec_state <= DELIVER;
                    end else begin
                        key_idx <= key_idx - 1'b1;
                    end
                end
                DELIVER: begin
                    if (!out_busy_i) begin
                        dec_state <= WAIT_BLOCK;
                    end
                end
                default: begin
                    dec_state <= LOAD_KEYS;
                end
            endcase
        end
    end

    // ------------------------------
    // key store, state and CBC chaining
    always_ff @(posedge clk) begin
        case (dec_state)
            LOAD_KEYS: begin
                if (word_take_o) begin
                    round_keys[key_idx] <= word_i;
                end
            end
            LOAD_IV: begin
                if (word_take_o) begin
                    chain_q <= word_i;
                end
            end
            WAIT_BLOCK: begin
                // keep the ciphertext, it chains into the next block
                if (word_take_o) begin
                    state_q  <= word_i;
                    cipher_q <= word_i;
                end
            end
            KEY_ADD: begin
                state_q <= state_q ^ round_keys[`AES_NUM_ROUNDS];
            end
            ROUNDS: begin
                state_q <= round_out;
            end
            DELIVER: begin
                if (!out_busy_i) begin
                    chain_q <= cipher_q;
                end
            end
        endcase
    end

    a_key_idx_range: assert property (
        @(posedge clk) disable iff (!resetn) key_idx <= round_idx_t'(`AES_NUM_ROUNDS)
    );

endmodule

/* hdl/aes_inv_round.sv */
`include "aes_params.svh"

module aes_inv_round (
    input  aes_data_pkg::aes_block_t state_i,
    input  aes_data_pkg::aes_block_t round_key_i,
    input  logic                     last_i,
    output aes_data_pkg::aes_block_t state_o
);
    import aes_data_pkg::*;

    localparam int NUM_BYTES = `AES_BLOCK_BITS / `AES_BYTE_BITS;

    // byte i sits at the top of the block for i = 0, column-major as in FIPS-197
    aes_byte_t in_b  [NUM_BYTES];
    aes_byte_t key_b [NUM_BYTES];
    aes_byte_t add_b [NUM_BYTES];
    aes_byte_t mix_b [NUM_BYTES];

    always_comb begin
        for (int i = 0; i < NUM_BYTES; i++) begin
            in_b[i]  = state_i[`AES_BLOCK_BITS - 1 - `AES_BYTE_BITS * i -: `AES_BYTE_BITS];
            key_b[i] = round_key_i[`AES_BLOCK_BITS - 1 - `AES_BYTE_BITS * i -: `AES_BYTE_BITS];
        end
    end

    // ------------------------------
    // inverse shift rows, inverse s-box, key add
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                // row r rotates right by r
                add_b[r + 4 * c] = inv_sbox(in_b[r + 4 * ((c + 4 - r) % 4)])
                                 ^ key_b[r + 4 * c];
            end
        end
    end

    // ------------------------------
    // inverse mix columns
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            mix_b[4 * c]     = gmul14(add_b[4 * c])     ^ gmul11(add_b[4 * c + 1])
                             ^ gmul13(add_b[4 * c + 2]) ^ gmul9(add_b[4 * c + 3]);
            mix_b[4 * c + 1] = gmul9(add_b[4 * c])      ^ gmul14(add_b[4 * c + 1])
                             ^ gmul11(add_b[4 * c + 2]) ^ gmul13(add_b[4 * c + 3]);
            mix_b[4 * c + 2] = gmul13(add_b[4 * c])     ^ gmul9(add_b[4 * c + 1])
                             ^ gmul14(add_b[4 * c + 2]) ^ gmul11(add_b[4 * c + 3]);
            mix_b[4 * c + 3] = gmul11(add_b[4 * c])     ^ gmul13(add_b[4 * c + 1])
                             ^ gmul9(add_b[4 * c + 2])  ^ gmul14(add_b[4 * c + 3]);
        end
    end

    // last round skips the column mix
    always_comb begin
        for (int i = 0; i < NUM_BYTES; i++) begin
            state_o[`AES_BLOCK_BITS - 1 - `AES_BYTE_BITS * i -: `AES_BYTE_BITS] =
                last_i ? add_b[i] : mix_b[i];
        end
    end

endmodule

/* hdl/aes_load_port.sv */
module aes_load_port (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     in_req_i,
    input  aes_data_pkg::aes_block_t in_data_i,
    output logic                     in_ack_o,
    output logic                     word_valid_o,
    output aes_data_pkg::aes_block_t word_o,
    input  logic                     word_take_i
);
    import aes_ctrl_pkg::*;

    rx_state_t rx_state;

    // ------------------------------
    // four-phase receiver
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rx_state <= RX_IDLE;
        end else begin
            case (rx_state)
                RX_IDLE: begin
                    // ack is low here, so a high req is always a fresh word
                    if (in_req_i) begin
                        rx_state <= RX_HELD;
                    end
                end
                RX_HELD: begin
                    // hold until the core consumes it
                    if (word_take_i) begin
                        rx_state <= RX_ACKED;
                    end
                end
                RX_ACKED: begin
                    if (!in_req_i) begin
                        rx_state <= RX_IDLE;
                    end
                end
                default: begin
                    rx_state <= RX_IDLE;
                end
            endcase
        end
    end

    // one-word buffer
    always_ff @(posedge clk) begin
        if (rx_state == RX_IDLE && in_req_i) begin
            word_o <= in_data_i;
        end
    end

    assign word_valid_o = (rx_state == RX_HELD);
    assign in_ack_o     = (rx_state == RX_ACKED);

    // host must still be requesting when we acknowledge
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!resetn) $rose(in_ack_o) |-> in_req_i
    );

endmodule

/* hdl/aes_ctrl_pkg.sv */
package aes_ctrl_pkg;

    // core sequencing, one block at a time
    typedef enum logic [2:0] {
        LOAD_KEYS,
        LOAD_IV,
        WAIT_BLOCK,
        KEY_ADD,
        ROUNDS,
        DELIVER
    } dec_state_t;

    // input receiver
    typedef enum logic [1:0] {RX_IDLE, RX_HELD, RX_ACKED} rx_state_t;

    // plaintext sender
    typedef enum logic [1:0] {TX_IDLE, TX_REQ, TX_WAIT_DROP} tx_state_t;

endpackage

/* hdl/aes_data_pkg.sv */
`include "aes_params.svh"

package aes_data_pkg;

    typedef logic [`AES_BLOCK_BITS-1:0] aes_block_t;
    typedef logic [`AES_BYTE_BITS-1:0]  aes_byte_t;
    typedef logic [3:0]                 round_idx_t;

    // ------------------------------
    // inverse s-box, entry 0 in the top byte
    localparam aes_byte_t [0:255] INV_SBOX = {
        128'h52096ad53036a538bf40a39e81f3d7fb,
        128'h7ce339829b2fff87348e4344c4dee9cb,
        128'h547b9432a6c2233dee4c950b42fac34e,
        128'h082ea16628d924b2765ba2496d8bd125,
        128'h72f8f66486689816d4a45ccc5d65b692,
        128'h6c704850fdedb9da5e154657a78d9d84,
        128'h90d8ab008cbcd30af7e45805b8b34506,
        128'hd02c1e8fca3f0f02c1afbd0301138a6b,
        128'h3a9111414f67dcea97f2cfcef0b4e673,
        128'h96ac7422e7ad3585e2f937e81c75df6e,
        128'h47f11a711d29c5896fb7620eaa18be1b,
        128'hfc563e4bc6d279209adbc0fe78cd5af4,
        128'h1fdda8338807c731b11210592780ec5f,
        128'h60517fa919b54a0d2de57a9f93c99cef,
        128'ha0e03b4dae2af5b0c8ebbb3c83539961,
        128'h172b047eba77d626e169146355210c7d
    };

    function automatic aes_byte_t inv_sbox(input aes_byte_t b);
        return INV_SBOX[b];
    endfunction

    // ------------------------------
    // GF(2^8) helpers, polynomial x^8 + x^4 + x^3 + x + 1

    // multiply by x
    function automatic aes_byte_t xtime(input aes_byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic aes_byte_t gmul9(input aes_byte_t b);
        aes_byte_t x8;
        x8 = xtime(xtime(xtime(b)));
        return x8 ^ b;
    endfunction

    function automatic aes_byte_t gmul11(input aes_byte_t b);
        aes_byte_t x2;
        aes_byte_t x8;
        x2 = xtime(b);
        x8 = xtime(xtime(x2));
        return x8 ^ x2 ^ b;
    endfunction

    function automatic aes_byte_t gmul13(input aes_byte_t b);
        aes_byte_t x4;
        aes_byte_t x8;
        x4 = xtime(xtime(b));
        x8 = xtime(x4);
        return x8 ^ x4 ^ b;
    endfunction

    function automatic aes_byte_t gmul14(input aes_byte_t b);
        aes_byte_t x2;
        aes_byte_t x4;
        aes_byte_t x8;
        x2 = xtime(b);
        x4 = xtime(x2);
        x8 = xtime(x4);
        return x8 ^ x4 ^ x2;
    endfunction

endpackage

/* hdl/aes_params.svh */
`ifndef AES_PARAMS_SVH
`define AES_PARAMS_SVH

// ------------------------------
// AES-256 sizes

// state, key and text block width
`define AES_BLOCK_BITS 128

// one state byte
`define AES_BYTE_BITS 8

// full rounds after the initial key add
`define AES_NUM_ROUNDS 14

// round keys held by the core, index 0 to 14
`define AES_NUM_ROUND_KEYS 15

`endif
